// File: dv/tb_shell_top.sv
`timescale 1ns/1ps

module tb_shell_top;

    localparam int EMU_WORDS  = 16;
    localparam int N_RAND     = 24;
    localparam int WAIT_LIMIT = 40;
    // Reset check, random bank, decouple, unmapped and back-pressure accesses
    localparam int N_ACCESS   = 2 + 2 * N_RAND + 15 + 10 + 3;
    localparam int WATCHDOG_CYCLES = N_ACCESS * 20 + 10;

    logic                   aclk;
    logic                   aresetn;
    logic                   aw_valid_i;
    shell_pkg::axil_addr_t  aw_i;
    logic                   aw_ready_o;
    logic                   w_valid_i;
    shell_pkg::axil_wdata_t w_i;
    logic                   w_ready_o;
    logic                   b_valid_o;
    shell_pkg::axil_resp_e  b_resp_o;
    logic                   b_ready_i;
    logic                   ar_valid_i;
    shell_pkg::axil_addr_t  ar_i;
    logic                   ar_ready_o;
    logic                   r_valid_o;
    shell_pkg::axil_rdata_t r_o;
    logic                   r_ready_i;

    logic [31:0] model_mem [EMU_WORDS];
    logic        model_decouple;
    logic [31:0] rng_state;
    int          resp_errors;
    int          data_errors;
    int          other_errors;

    shell_top #(
        .EMU_WORDS (EMU_WORDS)
    ) i_shell_top (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .aw_valid_i (aw_valid_i),
        .aw_i       (aw_i),
        .aw_ready_o (aw_ready_o),
        .w_valid_i  (w_valid_i),
        .w_i        (w_i),
        .w_ready_o  (w_ready_o),
        .b_valid_o  (b_valid_o),
        .b_resp_o   (b_resp_o),
        .b_ready_i  (b_ready_i),
        .ar_valid_i (ar_valid_i),
        .ar_i       (ar_i),
        .ar_ready_o (ar_ready_o),
        .r_valid_o  (r_valid_o),
        .r_o        (r_o),
        .r_ready_i  (r_ready_i)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Bank keeps only the low word address bits
    function automatic int model_index(input logic [19:0] addr);
        return (addr >> 2) % EMU_WORDS;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_resp(input string name, input shell_pkg::axil_resp_e got,
                              input shell_pkg::axil_resp_e exp);
        if (got !== exp) begin
            resp_errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // ========================================
    // Host access tasks
    // ========================================
    // Each task is entered on a rising edge
    task automatic do_write(input logic [19:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input shell_pkg::axil_resp_e exp_resp,
                            input int hold);
        int   cnt;
        logic accepted;
        aw_valid_i <= 1'b1;
        aw_i.addr  <= addr;
        w_valid_i  <= 1'b1;
        w_i.data   <= data;
        w_i.strb   <= strb;
        accepted = 1'b0;
        cnt = 0;
        while (!accepted && cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            accepted = aw_ready_o && w_ready_o;
            cnt++;
        end
        @(posedge aclk);
        aw_valid_i <= 1'b0;
        w_valid_i  <= 1'b0;
        if (!accepted) begin
            other_errors++;
            $display("Write to address %h was never accepted", addr);
            return;
        end
        cnt = 0;
        while (cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            if (b_valid_o) break;
            cnt++;
        end
        if (!b_valid_o) begin
            other_errors++;
            $display("Write to address %h got no response", addr);
            return;
        end
        if (cnt != 3) begin
            other_errors++;
            $display("Write response came %0d cycles after acceptance, not 3", cnt);
        end
        check_resp("b_resp_o", b_resp_o, exp_resp);
        repeat (hold) begin
            @(negedge aclk);
            if (!b_valid_o || aw_ready_o || w_ready_o || ar_ready_o) begin
                other_errors++;
                $display("B response dropped or a ready rose while b_ready_i was low");
            end
            check_resp("b_resp_o", b_resp_o, exp_resp);
        end
        @(posedge aclk);
        b_ready_i <= 1'b1;
        @(posedge aclk);
        b_ready_i <= 1'b0;
    endtask

    task automatic do_read(input logic [19:0] addr, input logic [31:0] exp_data,
                           input shell_pkg::axil_resp_e exp_resp, input int hold);
        int   cnt;
        logic accepted;
        ar_valid_i <= 1'b1;
        ar_i.addr  <= addr;
        accepted = 1'b0;
        cnt = 0;
        while (!accepted && cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            accepted = ar_ready_o;
            cnt++;
        end
        @(posedge aclk);
        ar_valid_i <= 1'b0;
        if (!accepted) begin
            other_errors++;
            $display("Read of address %h was never accepted", addr);
            return;
        end
        cnt = 0;
        while (cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            if (r_valid_o) break;
            cnt++;
        end
        if (!r_valid_o) begin
            other_errors++;
            $display("Read of address %h got no response", addr);
            return;
        end
        if (cnt != 3) begin
            other_errors++;
            $display("Read response came %0d cycles after acceptance, not 3", cnt);
        end
        check_resp("r_o.resp", r_o.resp, exp_resp);
        check_data("r_o.data", r_o.data, exp_data);
        repeat (hold) begin
            @(negedge aclk);
            if (!r_valid_o || aw_ready_o || w_ready_o || ar_ready_o) begin
                other_errors++;
                $display("R response dropped or a ready rose while r_ready_i was low");
            end
            check_resp("r_o.resp", r_o.resp, exp_resp);
            check_data("r_o.data", r_o.data, exp_data);
        end
        @(posedge aclk);
        r_ready_i <= 1'b1;
        @(posedge aclk);
        r_ready_i <= 1'b0;
    endtask

    // Expected answers follow the model bank and decouple bit
    task automatic emu_write(input logic [19:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold);
        int idx;
        idx = model_index(addr);
        if (!model_decouple) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) model_mem[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        do_write(addr, data, strb, model_decouple ? shell_pkg::SLVERR : shell_pkg::OKAY,
                 hold);
    endtask

    task automatic emu_read(input logic [19:0] addr, input int hold);
        if (model_decouple) begin
            do_read(addr, 32'h0, shell_pkg::SLVERR, hold);
        end else begin
            do_read(addr, model_mem[model_index(addr)], shell_pkg::OKAY, hold);
        end
    endtask

    task automatic ctrl_write(input logic [19:0] addr, input logic [31:0] data);
        model_decouple = data[0];
        do_write(addr, data, 4'hF, shell_pkg::OKAY, 0);
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_reset_state();
        @(negedge aclk);
        if (b_valid_o || r_valid_o || aw_ready_o || w_ready_o || ar_ready_o) begin
            other_errors++;
            $display("A valid or ready output is high right after reset");
        end
        @(posedge aclk);
        do_read(20'h5_0000, 32'h0, shell_pkg::OKAY, 0);
        emu_read(20'h0_0010, 0);
    endtask

    task automatic test_regfile_random();
        logic [31:0] data;
        logic [31:0] r;
        logic [19:0] addr;
        for (int i = 0; i < N_RAND; i++) begin
            r    = next_random();
            addr = {2'b00, r[15:0], 2'b00};
            data = next_random();
            r    = next_random();
            emu_write(addr, data, r[3:0], 0);
            // Read back through an alias one bank size higher
            emu_read((addr + 20'(EMU_WORDS * 4)) & 20'h3_FFFC, 0);
        end
    endtask

    task automatic test_decouple();
        logic [19:0] addrs [4];
        logic [31:0] r;
        ctrl_write(20'h5_0004, 32'h1);
        do_read(20'h5_0000, 32'h1, shell_pkg::OKAY, 0);
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            addrs[i] = {2'b00, r[15:0], 2'b00};
            emu_write(addrs[i], next_random(), 4'hF, 0);
        end
        foreach (addrs[i]) emu_read(addrs[i], 0);
        // Only bit 0 counts
        ctrl_write(20'h5_FFF0, 32'hFFFF_FFFE);
        foreach (addrs[i]) emu_read(addrs[i], 0);
    endtask

    task automatic test_unmapped();
        logic [19:0] addrs [4];
        addrs = '{20'h4_0000, 20'h4_FFFC, 20'h6_0000, 20'hF_FFFC};
        foreach (addrs[i]) begin
            do_write(addrs[i], next_random(), 4'hF, shell_pkg::DECERR, 0);
            do_read(addrs[i], 32'h0, shell_pkg::DECERR, 0);
        end
        // First and last words are where the unmapped writes would alias
        emu_read(20'h0_0000, 0);
        emu_read(20'((EMU_WORDS - 1) * 4), 0);
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        logic [19:0] addr;
        r    = next_random();
        addr = {2'b00, r[15:0], 2'b00};
        // Read offered with the write must wait and then see the new data
        ar_valid_i <= 1'b1;
        ar_i.addr  <= addr;
        emu_write(addr, next_random(), 4'hF, 5);
        emu_read(addr, 4);
        emu_read(addr + 20'h4, 2);
    endtask

    initial begin
        aresetn    = 1'b0;
        aw_valid_i = 1'b0;
        aw_i       = '0;
        w_valid_i  = 1'b0;
        w_i        = '0;
        b_ready_i  = 1'b0;
        ar_valid_i = 1'b0;
        ar_i       = '0;
        r_ready_i  = 1'b0;
        rng_state      = 32'hc886b3f6;
        model_decouple = 1'b0;
        resp_errors  = 0;
        data_errors  = 0;
        other_errors = 0;
        foreach (model_mem[i]) model_mem[i] = '0;

        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);

        test_reset_state();
        test_regfile_random();
        test_decouple();
        test_unmapped();
        test_backpressure();

        $display("Errors: resp %0d, data %0d, other %0d",
                 resp_errors, data_errors, other_errors);
        if (resp_errors + data_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: hw/emu_regfile.sv
`timescale 1ns/1ps

module emu_regfile #(
    parameter int EMU_WORDS = 16
) (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                req_valid_i,
    input  shell_pkg::tgt_req_t req_i,
    output logic                rsp_valid_o,
    output shell_pkg::tgt_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(EMU_WORDS);

    logic [shell_pkg::SHELL_DATA_W-1:0] mem_q [EMU_WORDS];
    logic                               rsp_valid_q;
    shell_pkg::tgt_rsp_t                rsp_q;
    logic [IDX_W-1:0]                   idx;

    // Upper word address bits are dropped, so the window aliases
    assign idx = req_i.addr[IDX_W-1:0];

    // Bank comes out of reset cleared, like the emulated design
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rsp_valid_q <= 1'b0;
            for (int w = 0; w < EMU_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else begin
            rsp_valid_q <= req_valid_i;
            if (req_valid_i && req_i.write) begin
                for (int b = 0; b < shell_pkg::SHELL_STRB_W; b++) begin
                    if (req_i.strb[b]) begin
                        mem_q[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid_i) begin
            rsp_q.resp <= shell_pkg::OKAY;
            rsp_q.data <= req_i.write ? '0 : mem_q[idx];
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

// File: hw/shell_axil_fsm.sv
`timescale 1ns/1ps

module shell_axil_fsm (
    input  logic                   aclk,
    input  logic                   aresetn,

    // Host write channels
    input  logic                   aw_valid_i,
    input  shell_pkg::axil_addr_t  aw_i,
    output logic                   aw_ready_o,
    input  logic                   w_valid_i,
    input  shell_pkg::axil_wdata_t w_i,
    output logic                   w_ready_o,
    output logic                   b_valid_o,
    output shell_pkg::axil_resp_e  b_resp_o,
    input  logic                   b_ready_i,

    // Host read channels
    input  logic                   ar_valid_i,
    input  shell_pkg::axil_addr_t  ar_i,
    output logic                   ar_ready_o,
    output logic                   r_valid_o,
    output shell_pkg::axil_rdata_t r_o,
    input  logic                   r_ready_i,

    // Target side
    output logic                   ctrl_req_valid_o,
    output logic                   emu_req_valid_o,
    output shell_pkg::tgt_req_t    req_o,
    input  logic                   ctrl_rsp_valid_i,
    input  shell_pkg::tgt_rsp_t    ctrl_rsp_i,
    input  logic                   emu_rsp_valid_i,
    input  shell_pkg::tgt_rsp_t    emu_rsp_i
);

    shell_pkg::shell_state_e state_q;
    shell_pkg::shell_win_e   win_q;
    logic                    is_write_q;
    logic                    wait_q;
    shell_pkg::tgt_req_t     req_q;
    shell_pkg::tgt_rsp_t     rsp_q;
    logic                    wr_accept;
    logic                    rd_accept;

    function automatic shell_pkg::shell_win_e decode(
        input logic [shell_pkg::SHELL_ADDR_W-1:0] addr
    );
        if ((addr & shell_pkg::EMU_MASK) == shell_pkg::EMU_BASE) begin
            return shell_pkg::WIN_EMU;
        end else if ((addr & shell_pkg::CTRL_MASK) == shell_pkg::CTRL_BASE) begin
            return shell_pkg::WIN_CTRL;
        end
        return shell_pkg::WIN_NONE;
    endfunction

    // Write wins when both kinds are offered in the same cycle
    assign wr_accept = (state_q == shell_pkg::ST_IDLE) && aw_valid_i && w_valid_i;
    assign rd_accept = (state_q == shell_pkg::ST_IDLE) && ar_valid_i &&
                       !(aw_valid_i && w_valid_i);

    assign aw_ready_o = wr_accept;
    assign w_ready_o  = wr_accept;
    assign ar_ready_o = rd_accept;

    // ========================================
    // Transaction sequencing
    // ========================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q    <= shell_pkg::ST_IDLE;
            win_q      <= shell_pkg::WIN_NONE;
            is_write_q <= 1'b0;
            wait_q     <= 1'b0;
        end else begin
            case (state_q)
                shell_pkg::ST_IDLE: begin
                    if (wr_accept) begin
                        is_write_q <= 1'b1;
                        win_q      <= decode(aw_i.addr);
                        state_q    <= shell_pkg::ST_ACCESS;
                    end else if (rd_accept) begin
                        is_write_q <= 1'b0;
                        win_q      <= decode(ar_i.addr);
                        state_q    <= shell_pkg::ST_ACCESS;
                    end
                end
                shell_pkg::ST_ACCESS: begin
                    state_q <= shell_pkg::ST_WAIT;
                end
                // Capture the target answer and present it one cycle later
                shell_pkg::ST_WAIT: begin
                    wait_q <= !wait_q;
                    if (wait_q) begin
                        state_q <= shell_pkg::ST_RESP;
                    end
                end
                shell_pkg::ST_RESP: begin
                    if ((is_write_q && b_ready_i) || (!is_write_q && r_ready_i)) begin
                        state_q <= shell_pkg::ST_IDLE;
                    end
                end
                default: state_q <= shell_pkg::ST_IDLE;
            endcase
        end
    end

    // ========================================
    // Request and response payload
    // ========================================
    always_ff @(posedge aclk) begin
        if (wr_accept) begin
            req_q.write <= 1'b1;
            req_q.addr  <= {2'b00, aw_i.addr[shell_pkg::SHELL_ADDR_W-1:2]};
            req_q.data  <= w_i.data;
            req_q.strb  <= w_i.strb;
        end else if (rd_accept) begin
            req_q.write <= 1'b0;
            req_q.addr  <= {2'b00, ar_i.addr[shell_pkg::SHELL_ADDR_W-1:2]};
            req_q.data  <= '0;
            req_q.strb  <= '0;
        end

        if (state_q == shell_pkg::ST_WAIT && !wait_q) begin
            case (win_q)
                shell_pkg::WIN_CTRL: begin
                    if (ctrl_rsp_valid_i) begin
                        rsp_q <= ctrl_rsp_i;
                    end
                end
                shell_pkg::WIN_EMU: begin
                    if (emu_rsp_valid_i) begin
                        rsp_q <= emu_rsp_i;
                    end
                end
                default: begin
                    rsp_q.data <= '0;
                    rsp_q.resp <= shell_pkg::DECERR;
                end
            endcase
        end
    end

    // Target strobes last exactly the one ST_ACCESS cycle
    assign ctrl_req_valid_o = (state_q == shell_pkg::ST_ACCESS) &&
                              (win_q == shell_pkg::WIN_CTRL);
    assign emu_req_valid_o  = (state_q == shell_pkg::ST_ACCESS) &&
                              (win_q == shell_pkg::WIN_EMU);
    assign req_o            = req_q;

    assign b_valid_o  = (state_q == shell_pkg::ST_RESP) && is_write_q;
    assign b_resp_o   = rsp_q.resp;
    assign r_valid_o  = (state_q == shell_pkg::ST_RESP) && !is_write_q;
    assign r_o.data   = rsp_q.data;
    assign r_o.resp   = rsp_q.resp;

endmodule

// File: hw/shell_ctrl_regs.sv
`timescale 1ns/1ps

module shell_ctrl_regs (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                req_valid_i,
    input  shell_pkg::tgt_req_t req_i,
    output logic                rsp_valid_o,
    output shell_pkg::tgt_rsp_t rsp_o,

    output logic                decouple_o
);

    logic                decouple_q;
    logic                rsp_valid_q;
    shell_pkg::tgt_rsp_t rsp_q;

    // Offset and strobe are ignored since the whole window is one register
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            decouple_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_valid_i;
            if (req_valid_i && req_i.write) begin
                decouple_q <= req_i.data[0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid_i) begin
            rsp_q.resp <= shell_pkg::OKAY;
            rsp_q.data <= req_i.write ? '0 :
                          {{(shell_pkg::SHELL_DATA_W-1){1'b0}}, decouple_q};
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;
    assign decouple_o  = decouple_q;

endmodule

// File: hw/shell_decoupler.sv
`timescale 1ns/1ps

module shell_decoupler (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                decouple_i,

    // From the transaction FSM
    input  logic                req_valid_i,
    input  shell_pkg::tgt_req_t req_i,
    output logic                rsp_valid_o,
    output shell_pkg::tgt_rsp_t rsp_o,

    // To the emulation register bank
    output logic                emu_req_valid_o,
    output shell_pkg::tgt_req_t emu_req_o,
    input  logic                emu_rsp_valid_i,
    input  shell_pkg::tgt_rsp_t emu_rsp_i
);

    logic blocked_q;

    // Blocked request answers on the same cycle the bank would have
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            blocked_q <= 1'b0;
        end else begin
            blocked_q <= req_valid_i && decouple_i;
        end
    end

    // Bank sees neither strobe nor payload while isolated
    assign emu_req_valid_o = req_valid_i && !decouple_i;
    assign emu_req_o       = decouple_i ? '0 : req_i;

    assign rsp_valid_o = emu_rsp_valid_i || blocked_q;
    assign rsp_o.data  = blocked_q ? '0 : emu_rsp_i.data;
    assign rsp_o.resp  = blocked_q ? shell_pkg::SLVERR : emu_rsp_i.resp;

endmodule

// File: hw/shell_pkg.sv
package shell_pkg;

    // ========================================
    // Address map and widths
    // ========================================
    localparam int SHELL_ADDR_W = 20;
    localparam int SHELL_DATA_W = 32;
    localparam int SHELL_STRB_W = SHELL_DATA_W / 8;

    // Emulation window covers 0x0_0000 to 0x3_FFFF
    localparam logic [SHELL_ADDR_W-1:0] EMU_BASE  = 20'h0_0000;
    localparam logic [SHELL_ADDR_W-1:0] EMU_MASK  = 20'hC_0000;

    // Every offset in the shell control window aliases the one register
    localparam logic [SHELL_ADDR_W-1:0] CTRL_BASE = 20'h5_0000;
    localparam logic [SHELL_ADDR_W-1:0] CTRL_MASK = 20'hF_0000;

    // ========================================
    // Enums
    // ========================================
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    typedef enum logic [1:0] {
        WIN_EMU,
        WIN_CTRL,
        WIN_NONE
    } shell_win_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_WAIT,
        ST_RESP
    } shell_state_e;

    // ========================================
    // Host channel payloads
    // ========================================
    typedef struct packed {
        logic [SHELL_ADDR_W-1:0] addr;
    } axil_addr_t;

    typedef struct packed {
        logic [SHELL_DATA_W-1:0] data;
        logic [SHELL_STRB_W-1:0] strb;
    } axil_wdata_t;

    typedef struct packed {
        logic [SHELL_DATA_W-1:0] data;
        axil_resp_e              resp;
    } axil_rdata_t;

    // Target requests carry the word address in addr
    typedef struct packed {
        logic                    write;
        logic [SHELL_ADDR_W-1:0] addr;
        logic [SHELL_DATA_W-1:0] data;
        logic [SHELL_STRB_W-1:0] strb;
    } tgt_req_t;

    typedef struct packed {
        logic [SHELL_DATA_W-1:0] data;
        axil_resp_e              resp;
    } tgt_rsp_t;

endpackage

// File: hw/shell_top.sv
`timescale 1ns/1ps

module shell_top #(
    parameter int EMU_WORDS = 16
) (
    input  logic                   aclk,
    input  logic                   aresetn,

    input  logic                   aw_valid_i,
    input  shell_pkg::axil_addr_t  aw_i,
    output logic                   aw_ready_o,
    input  logic                   w_valid_i,
    input  shell_pkg::axil_wdata_t w_i,
    output logic                   w_ready_o,
    output logic                   b_valid_o,
    output shell_pkg::axil_resp_e  b_resp_o,
    input  logic                   b_ready_i,

    input  logic                   ar_valid_i,
    input  shell_pkg::axil_addr_t  ar_i,
    output logic                   ar_ready_o,
    output logic                   r_valid_o,
    output shell_pkg::axil_rdata_t r_o,
    input  logic                   r_ready_i
);

    // ========================================
    // Internal request and response links
    // ========================================
    shell_pkg::tgt_req_t req;
    logic                ctrl_req_valid;
    logic                ctrl_rsp_valid;
    shell_pkg::tgt_rsp_t ctrl_rsp;
    logic                emu_req_valid;
    logic                emu_rsp_valid;
    shell_pkg::tgt_rsp_t emu_rsp;
    logic                decouple;

    // Gated side of the decoupler
    logic                bank_req_valid;
    shell_pkg::tgt_req_t bank_req;
    logic                bank_rsp_valid;
    shell_pkg::tgt_rsp_t bank_rsp;

    shell_axil_fsm u_fsm (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .aw_valid_i       (aw_valid_i),
        .aw_i             (aw_i),
        .aw_ready_o       (aw_ready_o),
        .w_valid_i        (w_valid_i),
        .w_i              (w_i),
        .w_ready_o        (w_ready_o),
        .b_valid_o        (b_valid_o),
        .b_resp_o         (b_resp_o),
        .b_ready_i        (b_ready_i),
        .ar_valid_i       (ar_valid_i),
        .ar_i             (ar_i),
        .ar_ready_o       (ar_ready_o),
        .r_valid_o        (r_valid_o),
        .r_o              (r_o),
        .r_ready_i        (r_ready_i),
        .ctrl_req_valid_o (ctrl_req_valid),
        .emu_req_valid_o  (emu_req_valid),
        .req_o            (req),
        .ctrl_rsp_valid_i (ctrl_rsp_valid),
        .ctrl_rsp_i       (ctrl_rsp),
        .emu_rsp_valid_i  (emu_rsp_valid),
        .emu_rsp_i        (emu_rsp)
    );

    shell_ctrl_regs u_ctrl_regs (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req_valid_i (ctrl_req_valid),
        .req_i       (req),
        .rsp_valid_o (ctrl_rsp_valid),
        .rsp_o       (ctrl_rsp),
        .decouple_o  (decouple)
    );

    shell_decoupler u_decoupler (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .decouple_i      (decouple),
        .req_valid_i     (emu_req_valid),
        .req_i           (req),
        .rsp_valid_o     (emu_rsp_valid),
        .rsp_o           (emu_rsp),
        .emu_req_valid_o (bank_req_valid),
        .emu_req_o       (bank_req),
        .emu_rsp_valid_i (bank_rsp_valid),
        .emu_rsp_i       (bank_rsp)
    );

    emu_regfile #(
        .EMU_WORDS (EMU_WORDS)
    ) u_emu_regfile (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req_valid_i (bank_req_valid),
        .req_i       (bank_req),
        .rsp_valid_o (bank_rsp_valid),
        .rsp_o       (bank_rsp)
    );

endmodule

// File: shell_top.f
hw/shell_pkg.sv
hw/shell_axil_fsm.sv
hw/shell_ctrl_regs.sv
hw/shell_decoupler.sv
hw/emu_regfile.sv
hw/shell_top.sv
dv/tb_shell_top.sv
